// File: all.f
hdl/conv_node_pkg.sv
hdl/packet_fifo.sv
hdl/instr_decoder.sv
hdl/filter_store.sv
hdl/ifmap_store.sv
hdl/conv_node_top.sv
test/conv_node_checker.sv
test/conv_node_monitor.sv
test/conv_node_tb.sv

// File: test/conv_node_tb.sv
`timescale 1ns/1ps

module conv_node_tb;

    localparam int num_items  = 300;  // packets or image bursts
    localparam int wait_limit = 400;  // cycles per wait loop

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        in_valid = 1'b0;
    logic [44:0] in_data = '0;
    logic        in_ready;
    logic [2:0]  fil_raddr = '0;
    logic [39:0] fil_rdata;
    logic [7:0]  if_raddr = '0;
    logic [35:0] if_rdata;
    logic        fil_inst_valid;
    logic [2:0]  fil_inst_row;
    logic        fil_inst_ready = 1'b0;
    logic        if_inst_valid;
    logic [7:0]  if_inst_info;
    logic        if_inst_ready = 1'b0;
    logic        fil_size_valid;
    logic [1:0]  fil_size;
    logic [13:0] pe_ack;
    logic        fil_chk = 1'b0;   // read-back compare strobes
    logic        if_chk = 1'b0;
    int          err_count;
    int          pending;
    int          seed = 13594;
    bit          timed_out = 1'b0;

    conv_node_top u_dut (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .fil_raddr(fil_raddr), .fil_rdata(fil_rdata), .if_raddr(if_raddr),
        .if_rdata(if_rdata), .fil_inst_valid(fil_inst_valid), .fil_inst_row(fil_inst_row),
        .fil_inst_ready(fil_inst_ready), .if_inst_valid(if_inst_valid),
        .if_inst_info(if_inst_info), .if_inst_ready(if_inst_ready),
        .fil_size_valid(fil_size_valid), .fil_size(fil_size), .pe_ack(pe_ack)
    );

    conv_node_monitor u_mon (.*);

    always #2 clk = ~clk;

    // instruction consumers stall about a third of the time
    always @(posedge clk) begin
        fil_inst_ready <= ({$random(seed)} % 3) != 0;
        if_inst_ready  <= ({$random(seed)} % 3) != 0;
    end

    function automatic logic [44:0] fil_packet(input logic [39:0] data,
                                               input logic [1:0] size, input logic ts);
        return {data, size, ts, 1'b1, 1'b1};
    endfunction

    function automatic logic [44:0] ifmap_packet(input logic [35:0] data,
                                                 input logic [5:0] side, input logic ts);
        return {data, side, ts, 1'b0, 1'b1};
    endfunction

    function automatic logic [44:0] ack_packet(input logic [3:0] node);
        return {40'd0, node, 1'b0};
    endfunction

    // hold valid and data until the fifo takes the word
    task automatic send_packet(input logic [44:0] p);
        int t;
        if (!timed_out) begin
            in_valid <= 1'b1;
            in_data  <= p;
            t = 0;
            do begin
                @(posedge clk);
                t++;
            end while (!in_ready && t < wait_limit);
            if (!in_ready) begin
                $display("timeout: input packet never taken, in_ready stayed low");
                timed_out = 1'b1;
            end
            in_valid <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        int t;
        if (!timed_out) begin
            t = 0;
            do begin
                @(posedge clk);
                t++;
            end while (pending != 0 && t < wait_limit);
            if (pending != 0) begin
                $display("timeout: %0d expected outputs never appeared", pending);
                timed_out = 1'b1;
            end
        end
    endtask

    // sweep both stores, the monitor compares one cycle behind
    task automatic read_back();
        if (!timed_out) begin
            for (int a = 0; a < 256; a++) begin
                if_raddr  <= a[7:0];
                if_chk    <= 1'b1;
                fil_raddr <= a[2:0];
                fil_chk   <= (a < 8);
                @(posedge clk);
            end
            if_chk  <= 1'b0;
            fil_chk <= 1'b0;
            repeat (2) @(posedge clk);  // last read data lands
        end
    endtask

    initial begin
        logic [63:0] r;
        logic        ts;
        int          kind;
        int          side;
        int          words;
        int          total;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);  // idle, nothing may come out yet
        for (int i = 0; i < num_items; i++) begin
            kind = {$random(seed)} % 10;
            r    = {$random(seed), $random(seed)};
            if (kind < 4) begin
                send_packet(fil_packet(r[39:0], r[41:40], r[42]));
            end else if (kind < 7) begin
                side  = 1 + ({$random(seed)} % 12);  // at most 4 words per image
                words = (side * side + 35) / 36;
                ts    = r[60];
                for (int k = 0; k < words; k++) begin
                    r = {$random(seed), $random(seed)};
                    send_packet(ifmap_packet(r[35:0], side[5:0], ts));
                end
            end else begin
                send_packet(ack_packet(r[3:0]));     // 14 and 15 included
            end
            repeat ({$random(seed)} % 3) @(posedge clk);
        end
        send_packet(ack_packet(4'd0));  // its pulse means all earlier packets are done
        wait_drained();
        read_back();
        total = err_count + u_dut.u_chk.fails + pending + int'(timed_out);
        $display("errors: %0d compare, %0d assertion, %0d missing, %0d timeout",
                 err_count, u_dut.u_chk.fails, pending, timed_out);
        if (total == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: test/conv_node_monitor.sv
`timescale 1ns/1ps

module conv_node_monitor (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [44:0] in_data,
    input  logic        in_ready,
    input  logic        fil_inst_valid,
    input  logic [2:0]  fil_inst_row,
    input  logic        fil_inst_ready,
    input  logic        if_inst_valid,
    input  logic [7:0]  if_inst_info,
    input  logic        if_inst_ready,
    input  logic        fil_size_valid,
    input  logic [1:0]  fil_size,
    input  logic [13:0] pe_ack,
    input  logic        fil_chk,    // read-back strobe from the testbench
    input  logic [2:0]  fil_raddr,
    input  logic [39:0] fil_rdata,
    input  logic        if_chk,
    input  logic [7:0]  if_raddr,
    input  logic [35:0] if_rdata,
    output int          err_count,
    output int          pending     // expected outputs not seen yet
);

    logic [2:0]  row_m;            // mirror of the filter row counter
    logic [6:0]  word_m;           // mirror of the ifmap word counter
    logic [1:0]  size_m;           // current filter size
    logic [39:0] fil_exp [8];
    bit          fil_set [8];      // row written at least once
    logic [35:0] if_exp [256];
    bit          if_set [256];
    logic [2:0]  fil_inst_q [$];
    logic [7:0]  if_inst_q [$];
    logic [1:0]  size_q [$];
    int          ack_q [$];
    logic        fil_chk_d;        // read address one cycle back
    logic [2:0]  fil_addr_d;
    logic        if_chk_d;
    logic [7:0]  if_addr_d;

    // decoding rules for one accepted packet update the mirror and the queues
    function automatic void apply_rules(input logic [44:0] p);
        int         side;
        int         w;
        logic [7:0] addr;
        side = int'(p[8:3]);
        w    = int'(word_m);
        if (!p[0]) begin
            if (p[4:1] < 4'd14)
                ack_q.push_back(int'(p[4:1]));  // 14 and 15 stay silent
        end else if (p[1]) begin
            fil_exp[row_m] = p[44:5];
            fil_set[row_m] = 1'b1;
            size_m = p[4:3];
            size_q.push_back(p[4:3]);
            fil_inst_q.push_back(row_m);
            row_m = row_m + 3'd1;              // wraps after row 7
        end else begin
            addr = {p[2], word_m};             // bank then word
            if_exp[addr] = p[44:9];
            if_set[addr] = 1'b1;
            if (36 * (w + 1) >= side * side) begin
                word_m = '0;
                if (p[2])
                    if_inst_q.push_back({p[8:3], size_m});
            end else begin
                word_m = word_m + 7'd1;
            end
        end
    endfunction

    task automatic log_mismatch(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
        err_count = err_count + 1;
    endtask

    task automatic unexpected_output(input string what);
        $display("unexpected %s at %0t with nothing outstanding", what, $time);
        err_count = err_count + 1;
    endtask

    always @(posedge clk) begin
        logic [2:0] exp_row;
        logic [7:0] exp_info;
        logic [1:0] exp_size;
        int         exp_node;
        if (rst) begin
            row_m  = '0;
            word_m = '0;
            size_m = '0;
            fil_inst_q.delete();
            if_inst_q.delete();
            size_q.delete();
            ack_q.delete();
            foreach (fil_set[i])
                fil_set[i] = 1'b0;
            foreach (if_set[i])
                if_set[i] = 1'b0;
            fil_chk_d = 1'b0;
            if_chk_d  = 1'b0;
            err_count = 0;
            pending  <= 0;
        end else begin
            if (fil_inst_valid && fil_inst_ready) begin
                if (fil_inst_q.size() == 0)
                    unexpected_output("filter instruction");
                else begin
                    exp_row = fil_inst_q.pop_front();
                    if (fil_inst_row !== exp_row)
                        log_mismatch("filter instruction row", fil_inst_row, exp_row);
                end
            end
            if (if_inst_valid && if_inst_ready) begin
                if (if_inst_q.size() == 0)
                    unexpected_output("ifmap instruction");
                else begin
                    exp_info = if_inst_q.pop_front();
                    if (if_inst_info !== exp_info)
                        log_mismatch("ifmap instruction info", if_inst_info, exp_info);
                end
            end
            if (fil_size_valid) begin
                if (size_q.size() == 0)
                    unexpected_output("filter size report");
                else begin
                    exp_size = size_q.pop_front();
                    if (fil_size !== exp_size)
                        log_mismatch("filter size", fil_size, exp_size);
                end
            end
            if (pe_ack != '0) begin
                if (ack_q.size() == 0)
                    unexpected_output("pe ack pulse");
                else begin
                    exp_node = ack_q.pop_front();
                    if (pe_ack !== (14'd1 << exp_node))
                        log_mismatch("pe ack bus", pe_ack, 14'd1 << exp_node);
                end
            end
            // read data belongs to the address sampled one edge earlier
            if (fil_chk_d && fil_set[fil_addr_d] && fil_rdata !== fil_exp[fil_addr_d])
                log_mismatch($sformatf("filter row %0d", fil_addr_d), fil_rdata,
                             fil_exp[fil_addr_d]);
            if (if_chk_d && if_set[if_addr_d] && if_rdata !== if_exp[if_addr_d])
                log_mismatch($sformatf("ifmap word %0h", if_addr_d), if_rdata,
                             if_exp[if_addr_d]);
            fil_chk_d  = fil_chk;
            fil_addr_d = fil_raddr;
            if_chk_d   = if_chk;
            if_addr_d  = if_raddr;
            if (in_valid && in_ready)
                apply_rules(in_data);         // packet enters the fifo here
            pending <= fil_inst_q.size() + if_inst_q.size() + size_q.size() + ack_q.size();
        end
    end

endmodule

// File: test/conv_node_checker.sv
`timescale 1ns/1ps

module conv_node_checker (
    input logic        clk,
    input logic        rst,
    input logic        fil_inst_valid,
    input logic [2:0]  fil_inst_row,
    input logic        fil_inst_ready,
    input logic        if_inst_valid,
    input logic [7:0]  if_inst_info,
    input logic        if_inst_ready,
    input logic        fil_size_valid,
    input logic [13:0] pe_ack
);

    int fails = 0;  // failed assertions, summed into the final count

    // instruction held with its payload until the consumer takes it
    a_fil_hold: assert property (@(posedge clk) disable iff (rst)
        fil_inst_valid && !fil_inst_ready |=> fil_inst_valid && $stable(fil_inst_row))
        else begin
            $error("filter instruction dropped or changed before ready");
            fails++;
        end

    a_if_hold: assert property (@(posedge clk) disable iff (rst)
        if_inst_valid && !if_inst_ready |=> if_inst_valid && $stable(if_inst_info))
        else begin
            $error("ifmap instruction dropped or changed before ready");
            fails++;
        end

    a_ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(pe_ack))
        else begin
            $error("more than one pe ack line high");
            fails++;
        end

    a_size_pulse: assert property (@(posedge clk) disable iff (rst)
        fil_size_valid |=> !fil_size_valid)  // one cycle per filter packet
        else begin
            $error("size report longer than one cycle");
            fails++;
        end

    // first cycle out of reset is quiet
    a_reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !fil_inst_valid && !if_inst_valid && !fil_size_valid && pe_ack == '0)
        else begin
            $error("output valid high right after reset");
            fails++;
        end

endmodule

bind conv_node_top conv_node_checker u_chk (.*);

// File: hdl/conv_node_top.sv
`timescale 1ns/1ps

module conv_node_top (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       in_valid,
    input  logic [conv_node_pkg::pkt_width-1:0]        in_data,
    output logic                                       in_ready,
    input  logic [conv_node_pkg::fil_row_bits-1:0]     fil_raddr,
    output logic [conv_node_pkg::fil_data_width-1:0]   fil_rdata,
    input  logic [conv_node_pkg::if_addr_bits-1:0]     if_raddr,
    output logic [conv_node_pkg::if_data_width-1:0]    if_rdata,
    output logic                                       fil_inst_valid,
    output logic [conv_node_pkg::fil_row_bits-1:0]     fil_inst_row,
    input  logic                                       fil_inst_ready,
    output logic                                       if_inst_valid,
    output logic [conv_node_pkg::if_side_bits+conv_node_pkg::fil_size_bits-1:0] if_inst_info,
    input  logic                                       if_inst_ready,
    output logic                                       fil_size_valid,
    output logic [conv_node_pkg::fil_size_bits-1:0]    fil_size,
    output logic [conv_node_pkg::pe_nodes-1:0]         pe_ack
);

    // fifo to decoder
    logic                                     pkt_valid;
    logic [conv_node_pkg::pkt_width-1:0]      pkt_data;
    logic                                     pkt_ready;

    // decoder to stores
    logic                                     fil_we;
    logic [conv_node_pkg::fil_row_bits-1:0]   fil_row;
    logic [conv_node_pkg::fil_data_width-1:0] fil_wdata;
    logic                                     if_we;
    logic [conv_node_pkg::if_addr_bits-1:0]   if_waddr;
    logic [conv_node_pkg::if_data_width-1:0]  if_wdata;

    packet_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (pkt_valid),
        .out_data  (pkt_data),
        .out_ready (pkt_ready)
    );

    instr_decoder u_dec (
        .clk            (clk),
        .rst            (rst),
        .pkt_valid      (pkt_valid),
        .pkt_data       (pkt_data),
        .pkt_ready      (pkt_ready),
        .fil_we         (fil_we),
        .fil_row        (fil_row),
        .fil_wdata      (fil_wdata),
        .if_we          (if_we),
        .if_waddr       (if_waddr),
        .if_wdata       (if_wdata),
        .fil_inst_valid (fil_inst_valid),
        .fil_inst_row   (fil_inst_row),
        .fil_inst_ready (fil_inst_ready),
        .if_inst_valid  (if_inst_valid),
        .if_inst_info   (if_inst_info),
        .if_inst_ready  (if_inst_ready),
        .fil_size_valid (fil_size_valid),
        .fil_size       (fil_size),
        .pe_ack         (pe_ack)
    );

    filter_store u_fil (
        .clk   (clk),
        .we    (fil_we),
        .waddr (fil_row),
        .wdata (fil_wdata),
        .raddr (fil_raddr),
        .rdata (fil_rdata)
    );

    ifmap_store u_if (
        .clk   (clk),
        .we    (if_we),
        .waddr (if_waddr),
        .wdata (if_wdata),
        .raddr (if_raddr),
        .rdata (if_rdata)
    );

endmodule

// File: hdl/ifmap_store.sv
`timescale 1ns/1ps

module ifmap_store (
    input  logic                                    clk,
    input  logic                                    we,
    input  logic [conv_node_pkg::if_addr_bits-1:0]  waddr,
    input  logic [conv_node_pkg::if_data_width-1:0] wdata,
    input  logic [conv_node_pkg::if_addr_bits-1:0]  raddr,
    output logic [conv_node_pkg::if_data_width-1:0] rdata
);

    // two banks so one timestep fills while the other is read
    logic [conv_node_pkg::if_data_width-1:0] bank0 [conv_node_pkg::if_mem_depth/2];
    logic [conv_node_pkg::if_data_width-1:0] bank1 [conv_node_pkg::if_mem_depth/2];

    logic                                   wr_bank;  // address msb is the timestep
    logic [conv_node_pkg::if_word_bits-1:0] wr_word;
    logic                                   rd_bank;
    logic [conv_node_pkg::if_word_bits-1:0] rd_word;

    assign wr_bank = waddr[conv_node_pkg::if_addr_bits-1];
    assign wr_word = waddr[conv_node_pkg::if_word_bits-1:0];
    assign rd_bank = raddr[conv_node_pkg::if_addr_bits-1];
    assign rd_word = raddr[conv_node_pkg::if_word_bits-1:0];

    always_ff @(posedge clk) begin
        if (we && !wr_bank)
            bank0[wr_word] <= wdata;
        if (we && wr_bank)
            bank1[wr_word] <= wdata;
    end

    // registered read through the bank mux
    always_ff @(posedge clk) begin
        rdata <= rd_bank ? bank1[rd_word] : bank0[rd_word];
    end

endmodule

// File: hdl/filter_store.sv
`timescale 1ns/1ps

module filter_store (
    input  logic                                     clk,
    input  logic                                     we,
    input  logic [conv_node_pkg::fil_row_bits-1:0]   waddr,
    input  logic [conv_node_pkg::fil_data_width-1:0] wdata,
    input  logic [conv_node_pkg::fil_row_bits-1:0]   raddr,
    output logic [conv_node_pkg::fil_data_width-1:0] rdata
);

    // one entry per filter row, overwritten as new filters come in
    logic [conv_node_pkg::fil_data_width-1:0] rows [conv_node_pkg::fil_rows];

    always_ff @(posedge clk) begin
        if (we)
            rows[waddr] <= wdata;
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= rows[raddr];
    end

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       pkt_valid,
    input  logic [conv_node_pkg::pkt_width-1:0]        pkt_data,
    output logic                                       pkt_ready,
    output logic                                       fil_we,
    output logic [conv_node_pkg::fil_row_bits-1:0]     fil_row,
    output logic [conv_node_pkg::fil_data_width-1:0]   fil_wdata,
    output logic                                       if_we,
    output logic [conv_node_pkg::if_addr_bits-1:0]     if_waddr,
    output logic [conv_node_pkg::if_data_width-1:0]    if_wdata,
    output logic                                       fil_inst_valid,
    output logic [conv_node_pkg::fil_row_bits-1:0]     fil_inst_row,
    input  logic                                       fil_inst_ready,
    output logic                                       if_inst_valid,
    output logic [conv_node_pkg::if_side_bits+conv_node_pkg::fil_size_bits-1:0] if_inst_info,
    input  logic                                       if_inst_ready,
    output logic                                       fil_size_valid,
    output logic [conv_node_pkg::fil_size_bits-1:0]    fil_size,
    output logic [conv_node_pkg::pe_nodes-1:0]         pe_ack
);

    conv_node_pkg::packet_u pkt;  // same word seen as filter, ifmap or ack
    logic accept;
    logic is_fil;
    logic is_ifm;
    logic is_ack;

    logic [conv_node_pkg::fil_row_bits-1:0] row_cnt;  // next filter row to fill
    logic [conv_node_pkg::if_word_bits-1:0] word_cnt; // word index in current image

    // end of image check operands
    logic [conv_node_pkg::img_cnt_bits-1:0] word_ext;
    logic [conv_node_pkg::img_cnt_bits-1:0] side_ext;
    logic img_done;

    assign pkt = pkt_data;

    // hold off input while an instruction waits so only one is ever pending
    assign pkt_ready = !fil_inst_valid && !if_inst_valid;
    assign accept    = pkt_valid && pkt_ready;

    assign is_fil = pkt.fil.src && pkt.fil.kind;
    assign is_ifm = pkt.ifm.src && !pkt.ifm.kind;
    assign is_ack = !pkt.ack.src;                 // kind bit is don't care here

    assign word_ext = {{(conv_node_pkg::img_cnt_bits-conv_node_pkg::if_word_bits){1'b0}},
                       word_cnt};
    assign side_ext = {{(conv_node_pkg::img_cnt_bits-conv_node_pkg::if_side_bits){1'b0}},
                       pkt.ifm.side};

    // pixels collected including this word against side squared
    assign img_done = ((word_ext + 1'b1) * conv_node_pkg::if_data_width) >=
                      (side_ext * side_ext);

    always_ff @(posedge clk) begin
        if (rst) begin
            fil_we         <= 1'b0;
            if_we          <= 1'b0;
            fil_size_valid <= 1'b0;
            fil_inst_valid <= 1'b0;
            if_inst_valid  <= 1'b0;
            pe_ack         <= '0;
            row_cnt        <= '0;
            word_cnt       <= '0;
            fil_size       <= '0;  // no filter seen yet
        end else begin
            // single cycle strobes
            fil_we         <= accept && is_fil;
            fil_size_valid <= accept && is_fil;
            if_we          <= accept && is_ifm;

            // one hot ack, nodes past the bus width match nothing
            for (int i = 0; i < conv_node_pkg::pe_nodes; i++) begin
                pe_ack[i] <= accept && is_ack && (pkt.ack.node == i);
            end

            if (fil_inst_valid && fil_inst_ready)
                fil_inst_valid <= 1'b0;
            if (if_inst_valid && if_inst_ready)
                if_inst_valid <= 1'b0;

            if (accept && is_fil) begin
                fil_size       <= pkt.fil.size;    // becomes the current filter size
                fil_inst_valid <= 1'b1;
                row_cnt        <= row_cnt + 1'b1;  // wraps after row 7
            end

            if (accept && is_ifm) begin
                if (img_done) begin
                    word_cnt <= '0;
                    if (pkt.ifm.ts)
                        if_inst_valid <= 1'b1; // only timestep 1 images start work
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // payload registers, qualified by the strobes and valids above
    always_ff @(posedge clk) begin
        if (accept && is_fil) begin
            fil_row      <= row_cnt;
            fil_wdata    <= pkt.fil.data;
            fil_inst_row <= row_cnt;  // stays put while the instruction waits
        end
        if (accept && is_ifm) begin
            if_waddr     <= {pkt.ifm.ts, word_cnt}; // bank then word
            if_wdata     <= pkt.ifm.data;
            if_inst_info <= {pkt.ifm.side, fil_size};
        end
    end

endmodule

// File: hdl/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    input  logic [conv_node_pkg::pkt_width-1:0] in_data,
    output logic                              in_ready,
    output logic                              out_valid,
    output logic [conv_node_pkg::pkt_width-1:0] out_data,
    input  logic                              out_ready
);

    logic [conv_node_pkg::pkt_width-1:0] mem [conv_node_pkg::fifo_depth]; // packet slots
    logic [conv_node_pkg::fifo_ptr_bits-1:0] wr_ptr;
    logic [conv_node_pkg::fifo_ptr_bits-1:0] rd_ptr;
    logic [conv_node_pkg::fifo_ptr_bits:0]   count;  // one bit more than the pointers
    logic push;
    logic pop;

    assign in_ready  = (count != conv_node_pkg::fifo_depth); // low only when full
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];                            // head word

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1; // push and pop together keep the count
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

// File: hdl/conv_node_pkg.sv
package conv_node_pkg;

    // packet and payload widths
    localparam int pkt_width      = 45;
    localparam int fil_data_width = 40;  // five 8-bit weights per row
    localparam int if_data_width  = 36;  // image pixels carried per ifmap packet

    // header field widths
    localparam int fil_size_bits  = 2;
    localparam int if_side_bits   = 6;   // ifmap side length
    localparam int pe_node_bits   = 4;

    // filter store
    localparam int fil_rows       = 8;
    localparam int fil_row_bits   = $clog2(fil_rows);

    // ifmap store is two banks of if_words selected by the timestep bit
    localparam int if_words       = 128;
    localparam int if_word_bits   = $clog2(if_words);
    localparam int if_mem_depth   = 2 * if_words;
    localparam int if_addr_bits   = $clog2(if_mem_depth);

    localparam int pe_nodes       = 14;  // ack lines, nodes 14 and 15 unused
    localparam int fifo_depth     = 4;
    localparam int fifo_ptr_bits  = $clog2(fifo_depth);

    // wide enough for 36 * 128 pixels and for 63 * 63
    localparam int img_cnt_bits   = 13;

    // one packet word, three ways to read it
    // bit 0 is the source in every view (1 external input, 0 pe ack)
    typedef union packed {
        struct packed {
            logic [fil_data_width-1:0] data;  // filter row
            logic [fil_size_bits-1:0]  size;
            logic                      ts;    // timestep
            logic                      kind;  // 1 for filter
            logic                      src;
        } fil;
        struct packed {
            logic [if_data_width-1:0]  data;  // image data
            logic [if_side_bits-1:0]   side;
            logic                      ts;    // selects the store bank
            logic                      kind;  // 0 for ifmap
            logic                      src;
        } ifm;
        struct packed {
            logic [pkt_width-pe_node_bits-2:0] pad;  // all zero
            logic [pe_node_bits-1:0]           node; // acking pe
            logic                              src;  // 0 here
        } ack;
    } packet_u;

endpackage
